//--- verilog/cpuPkg.sv
package cpuPkg;

    parameter int DataWidth = 32;    // Default datapath word width
    parameter int AddrWidth = 9;     // Default RAM address width for 512 words
    parameter int NumRegs = 16;      // General purpose registers R0..R15
    parameter int InstrWidth = 32;   // Instruction word as held in IR
    parameter int ImmWidth = 19;     // Immediate field of the branch/immediate form
    parameter int ShamtWidth = 5;    // Shift amount taken from the bus

    typedef enum logic [4:0] {
        OpAdd = 5'b00011,
        OpSub = 5'b00100,
        OpAnd = 5'b00101,
        OpOr  = 5'b00110,
        OpShr = 5'b00111,
        OpShl = 5'b01001,
        OpMul = 5'b01111,
        OpNeg = 5'b10001,
        OpNot = 5'b10010
    } aluOp_t;

    // Same instruction bits read as register form or branch/immediate form
    typedef union packed {
        struct packed {
            logic [4:0]  op;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] unused;
        } regForm;
        struct packed {
            logic [4:0]  op;
            logic [3:0]  ra;
            logic [1:0]  c2;       // Branch condition code
            logic [1:0]  unused;
            logic [18:0] imm;
        } immForm;
    } instrWord_t;

endpackage

//--- verilog/busSourcesIf.sv
`timescale 1ns/1ps

interface busSourcesIf #(
    parameter int DataWidth = cpuPkg::DataWidth
);

    logic [DataWidth-1:0] regWord;
    logic [DataWidth-1:0] pcWord;
    logic [DataWidth-1:0] mdrWord;
    logic [DataWidth-1:0] zHiWord;
    logic [DataWidth-1:0] zLoWord;
    logic [DataWidth-1:0] hiWord;
    logic [DataWidth-1:0] loWord;
    logic [DataWidth-1:0] inportWord;
    logic [DataWidth-1:0] cWord;
    logic [DataWidth-1:0] busValue;   // Shared bus seen by every register

    modport mux (
        input  regWord, pcWord, mdrWord, zHiWord, zLoWord,
        input  hiWord, loWord, inportWord, cWord,
        output busValue
    );
    modport regSrc   (output regWord, input busValue);
    modport instrSrc (output pcWord, cWord, input busValue);
    modport aluSrc   (output zHiWord, zLoWord, hiWord, loWord, input busValue);
    modport memSrc   (output mdrWord, input busValue);
    modport ioSrc    (output inportWord, input busValue);

endinterface

//--- verilog/busMux.sv
`timescale 1ns/1ps

module busMux (
    input logic      Clock,
    input logic      rstN,
    busSourcesIf.mux bus,
    input logic      hiOut,
    input logic      loOut,
    input logic      zHiOut,
    input logic      zLoOut,
    input logic      pcOut,
    input logic      mdrOut,
    input logic      inportOut,
    input logic      cOut,
    input logic      regOut
);

    // Enabled sources are OR-ed together, so an idle bus reads zero
    always_comb begin
        bus.busValue = '0;
        if (hiOut) bus.busValue |= bus.hiWord;
        if (loOut) bus.busValue |= bus.loWord;
        if (zHiOut) bus.busValue |= bus.zHiWord;
        if (zLoOut) bus.busValue |= bus.zLoWord;
        if (pcOut) bus.busValue |= bus.pcWord;
        if (mdrOut) bus.busValue |= bus.mdrWord;
        if (inportOut) bus.busValue |= bus.inportWord;
        if (cOut) bus.busValue |= bus.cWord;
        if (regOut) bus.busValue |= bus.regWord;
    end

    // Controller must never drive two sources in one cycle
    assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0({hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut, regOut}))
        else $error("busMux: more than one bus source enabled");

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input logic               Clock,
    input logic               rstN,
    input logic               gra,
    input logic               grb,
    input logic               grc,
    input logic               rIn,
    input logic               rOut,
    input logic               baOut,
    input cpuPkg::instrWord_t ir,
    busSourcesIf.regSrc       bus
);

    import cpuPkg::*;

    localparam int IdxWidth = $clog2(NumRegs);

    logic [DataWidth-1:0] regs [NumRegs];
    logic [IdxWidth-1:0]  selIdx;

    // One of the three IR fields picks the register
    assign selIdx = ({IdxWidth{gra}} & ir.regForm.ra)
                  | ({IdxWidth{grb}} & ir.regForm.rb)
                  | ({IdxWidth{grc}} & ir.regForm.rc);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[selIdx] <= bus.busValue;
        end
    end

    always_comb begin
        if (baOut && selIdx == '0) begin
            bus.regWord = '0;               // R0 reads zero in base address form
        end else if (rOut || baOut) begin
            bus.regWord = regs[selIdx];
        end else begin
            bus.regWord = '0;
        end
    end

    // An ambiguous field select would write or read the wrong register
    assert property (@(posedge Clock) disable iff (!rstN)
        (rIn || rOut || baOut) |-> $onehot0({gra, grb, grc}))
        else $error("registerFile: more than one register field select");

endmodule

//--- verilog/instructionUnit.sv
`timescale 1ns/1ps

module instructionUnit #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               conIn,
    output cpuPkg::instrWord_t ir,
    output logic               conFf,
    busSourcesIf.instrSrc      bus
);

    import cpuPkg::*;

    logic [DataWidth-1:0] pc;
    logic                 condMet;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            ir    <= '0;
            conFf <= 1'b0;
        end else begin
            if (pcIn) pc <= bus.busValue;
            if (irIn) ir <= bus.busValue[InstrWidth-1:0];
            if (conIn) conFf <= condMet;
        end
    end

    assign bus.pcWord = pc;
    // Sign-extended immediate for Cout
    assign bus.cWord = {{(DataWidth-ImmWidth){ir.immForm.imm[ImmWidth-1]}}, ir.immForm.imm};

    always_comb begin
        case (ir.immForm.c2)
            2'b00:   condMet = (bus.busValue == '0);    // Branch if zero
            2'b01:   condMet = (bus.busValue != '0);    // Branch if nonzero
            2'b10:   condMet = !bus.busValue[DataWidth-1];
            default: condMet = bus.busValue[DataWidth-1];
        endcase
    end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input logic           Clock,
    input logic           rstN,
    input logic           yIn,
    input logic           zIn,
    input logic           hiIn,
    input logic           loIn,
    input logic           incPc,
    input cpuPkg::aluOp_t opcode,
    busSourcesIf.aluSrc   bus
);

    import cpuPkg::*;

    localparam int WideWidth = 2 * DataWidth;

    logic [DataWidth-1:0]        yReg;
    logic [DataWidth-1:0]        hiReg;
    logic [DataWidth-1:0]        loReg;
    logic [WideWidth-1:0]        zReg;
    logic [DataWidth-1:0]        lowResult;
    logic [WideWidth-1:0]        aluResult;
    logic signed [WideWidth-1:0] product;
    logic [ShamtWidth-1:0]       shamt;

    assign shamt = bus.busValue[ShamtWidth-1:0];
    assign product = $signed(yReg) * $signed(bus.busValue);   // Full signed product

    always_comb begin
        if (incPc) begin
            lowResult = bus.busValue + 1'b1;    // PC increment overrides opcode
        end else begin
            case (opcode)
                OpAdd:   lowResult = yReg + bus.busValue;
                OpSub:   lowResult = yReg - bus.busValue;
                OpAnd:   lowResult = yReg & bus.busValue;
                OpOr:    lowResult = yReg | bus.busValue;
                OpShr:   lowResult = yReg >> shamt;
                OpShl:   lowResult = yReg << shamt;
                OpMul:   lowResult = product[DataWidth-1:0];
                OpNeg:   lowResult = -bus.busValue;
                OpNot:   lowResult = ~bus.busValue;
                default: lowResult = '0;
            endcase
        end
        if (!incPc && opcode == OpMul) begin
            aluResult = product;
        end else begin
            aluResult = {{DataWidth{lowResult[DataWidth-1]}}, lowResult};
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            yReg  <= '0;
            zReg  <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (yIn) yReg <= bus.busValue;
            if (zIn) zReg <= aluResult;
            if (hiIn) hiReg <= bus.busValue;
            if (loIn) loReg <= bus.busValue;
        end
    end

    assign bus.zHiWord = zReg[WideWidth-1:DataWidth];
    assign bus.zLoWord = zReg[DataWidth-1:0];
    assign bus.hiWord  = hiReg;
    assign bus.loWord  = loReg;

    // Z would silently capture zero for an undefined opcode
    assert property (@(posedge Clock) disable iff (!rstN)
        (zIn && !incPc) |->
            opcode inside {OpAdd, OpSub, OpAnd, OpOr, OpShr, OpShl, OpMul, OpNeg, OpNot})
        else $error("aluUnit: undefined opcode %b captured into Z", opcode);

endmodule

//--- verilog/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface #(
    parameter int DataWidth = cpuPkg::DataWidth,
    parameter int AddrWidth = cpuPkg::AddrWidth
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 memOverride,
    input  logic [AddrWidth-1:0] overrideAddr,
    input  logic [DataWidth-1:0] overrideData,
    output logic [AddrWidth-1:0] marAddress,
    busSourcesIf.memSrc          bus
);

    localparam int Depth = 2 ** AddrWidth;

    logic [DataWidth-1:0] ram [Depth];
    logic [AddrWidth-1:0] mar;
    logic [DataWidth-1:0] mdr;
    logic [DataWidth-1:0] readWord;

    assign readWord = ram[mar];   // Asynchronous read at MAR

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) mar <= bus.busValue[AddrWidth-1:0];
            if (mdrIn) mdr <= memRead ? readWord : bus.busValue;
        end
    end

    // Preload port wins over a normal store
    always_ff @(posedge Clock) begin
        if (memOverride) begin
            ram[overrideAddr] <= overrideData;
        end else if (memWrite) begin
            ram[mar] <= mdr;
        end
    end

    assign bus.mdrWord = mdr;
    assign marAddress  = mar;

    assert property (@(posedge Clock) disable iff (!rstN) !(memRead && memWrite))
        else $error("memoryInterface: read and write requested together");

endmodule

//--- verilog/ioPorts.sv
`timescale 1ns/1ps

module ioPorts #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 inportStrobe,
    input  logic                 outportIn,
    input  logic [DataWidth-1:0] inportData,
    output logic [DataWidth-1:0] outportData,
    busSourcesIf.ioSrc           bus
);

    logic [DataWidth-1:0] inportReg;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            inportReg   <= '0;
            outportData <= '0;
        end else begin
            if (inportStrobe) inportReg <= inportData;   // Sample external word
            if (outportIn) outportData <= bus.busValue;
        end
    end

    assign bus.inportWord = inportReg;

endmodule

//--- verilog/busCpuDatapath.sv
`timescale 1ns/1ps

module busCpuDatapath #(
    parameter int DataWidth = cpuPkg::DataWidth,
    parameter int AddrWidth = cpuPkg::AddrWidth
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 zHiOut,
    input  logic                 zLoOut,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 inportOut,
    input  logic                 cOut,
    input  logic                 marIn,
    input  logic                 zIn,
    input  logic                 pcIn,
    input  logic                 mdrIn,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 outportIn,
    input  logic                 inportStrobe,
    input  logic                 incPc,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    input  logic                 conIn,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 memOverride,
    input  cpuPkg::aluOp_t       opcode,
    input  logic [DataWidth-1:0] inportData,
    input  logic [AddrWidth-1:0] overrideAddr,
    input  logic [DataWidth-1:0] overrideData,
    output logic [DataWidth-1:0] busValue,
    output logic [DataWidth-1:0] outportData,
    output logic                 conFf,
    output logic [AddrWidth-1:0] marAddress
);

    import cpuPkg::*;

    instrWord_t ir;   // IR fields feed the register select

    busSourcesIf #(.DataWidth(DataWidth)) bus ();

    assign busValue = bus.busValue;

    busMux uBusMux (
        .Clock(Clock), .rstN(rstN), .bus(bus),
        .hiOut(hiOut), .loOut(loOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
        .pcOut(pcOut), .mdrOut(mdrOut), .inportOut(inportOut), .cOut(cOut),
        .regOut(rOut | baOut)   // Either register read strobe claims the bus
    );

    registerFile #(.DataWidth(DataWidth)) uRegisterFile (
        .Clock(Clock), .rstN(rstN), .gra(gra), .grb(grb), .grc(grc),
        .rIn(rIn), .rOut(rOut), .baOut(baOut), .ir(ir), .bus(bus)
    );

    instructionUnit #(.DataWidth(DataWidth)) uInstructionUnit (
        .Clock(Clock), .rstN(rstN), .pcIn(pcIn), .irIn(irIn), .conIn(conIn),
        .ir(ir), .conFf(conFf), .bus(bus)
    );

    aluUnit #(.DataWidth(DataWidth)) uAluUnit (
        .Clock(Clock), .rstN(rstN), .yIn(yIn), .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
        .incPc(incPc), .opcode(opcode), .bus(bus)
    );

    memoryInterface #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) uMemoryInterface (
        .Clock(Clock), .rstN(rstN), .marIn(marIn), .mdrIn(mdrIn),
        .memRead(memRead), .memWrite(memWrite), .memOverride(memOverride),
        .overrideAddr(overrideAddr), .overrideData(overrideData),
        .marAddress(marAddress), .bus(bus)
    );

    ioPorts #(.DataWidth(DataWidth)) uIoPorts (
        .Clock(Clock), .rstN(rstN), .inportStrobe(inportStrobe), .outportIn(outportIn),
        .inportData(inportData), .outportData(outportData), .bus(bus)
    );

endmodule

//--- tests/datapathTbTasks.svh
// Drops every strobe so the bus idles at zero
task automatic clearStrobes();
    {hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut, marIn, zIn, pcIn,
     mdrIn, irIn, yIn, hiIn, loIn, outportIn, inportStrobe, incPc, gra, grb, grc,
     rIn, rOut, baOut, conIn, memRead, memWrite, memOverride} = '0;
endtask

// Holds the caller's strobes for one cycle and sets what the bus must show
task automatic endCycle(input logic [31:0] busExpected);
    expBus = busExpected;
    @(posedge Clock);
    #2;
    clearStrobes();
    expBus = '0;
endtask

task automatic preloadWord(input logic [AddrWidth-1:0] addr, input logic [31:0] data);
    memOverride = 1'b1;
    overrideAddr = addr;
    overrideData = data;
    endCycle('0);
endtask

// Word enters through the inport and then crosses the bus into the chosen registers
task automatic busTransfer(input logic [31:0] value, input logic [7:0] dests);
    inportData = value;
    inportStrobe = 1'b1;
    endCycle('0);
    inportOut = 1'b1;
    irIn = |(dests & ToIr);
    pcIn = |(dests & ToPc);
    marIn = |(dests & ToMar);
    mdrIn = |(dests & ToMdr);
    outportIn = |(dests & ToOut);
    {rIn, gra} = {2{|(dests & ToReg)}};   // Target is the ra field of IR
    conIn = |(dests & ToCon);
    endCycle(value);
    if ((dests & ToIr) != 0) modelC2 = value[22:21];
    if ((dests & ToPc) != 0) modelPc = value;
    if ((dests & ToMar) != 0) expMar = value[AddrWidth-1:0];
    if ((dests & ToOut) != 0) expOut = value;
    if ((dests & ToCon) != 0) expCon = branchTaken(modelC2, value);
endtask

task automatic loadReg(input logic [3:0] idx, input logic [31:0] value);
    busTransfer(regInstr(idx, 4'd0, 4'd0), ToIr);
    busTransfer(value, ToReg);
    {rOut, gra} = '1;   // Read back
    endCycle(value);
endtask

// R1 gets R2 op R3 and the result also passes through HI and LO
task automatic aluOp(input aluOp_t op, input logic [31:0] a, input logic [31:0] b);
    logic [63:0] expected;
    expected = aluModel(op, a, b);
    loadReg(4'd2, a);
    loadReg(4'd3, b);
    busTransfer(regInstr(4'd1, 4'd2, 4'd3), ToIr);
    {rOut, grb, yIn} = '1;
    endCycle(a);
    {rOut, grc, zIn} = '1;
    opcode = op;
    endCycle(b);
    {zLoOut, rIn, gra, loIn} = '1;
    endCycle(expected[31:0]);
    {zHiOut, hiIn} = '1;
    endCycle(expected[63:32]);
    hiOut = 1'b1;
    endCycle(expected[63:32]);
    loOut = 1'b1;
    endCycle(expected[31:0]);
    {rOut, gra} = '1;
    endCycle(expected[31:0]);
endtask

task automatic fetch(input logic [31:0] word);
    logic [31:0] nextPc;
    nextPc = modelPc + 1;
    preloadWord(nextPc[AddrWidth-1:0], word);
    {pcOut, incPc, zIn} = '1;
    endCycle(modelPc);
    {zLoOut, pcIn} = '1;
    endCycle(nextPc);
    modelPc = nextPc;
    {pcOut, marIn} = '1;
    endCycle(nextPc);
    expMar = nextPc[AddrWidth-1:0];
    {memRead, mdrIn} = '1;
    endCycle('0);
    {mdrOut, irIn} = '1;
    endCycle(word);
    modelC2 = word[22:21];
    cOut = 1'b1;
    endCycle({{13{word[18]}}, word[18:0]});   // Sign-extended imm
endtask

//--- tests/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;

    import cpuPkg::*;

    localparam int TimeoutCycles = 3000;   // About five times the test length
    localparam logic [7:0] ToIr = 8'h01;
    localparam logic [7:0] ToPc = 8'h02;
    localparam logic [7:0] ToMar = 8'h04;
    localparam logic [7:0] ToMdr = 8'h08;
    localparam logic [7:0] ToOut = 8'h10;
    localparam logic [7:0] ToReg = 8'h20;
    localparam logic [7:0] ToCon = 8'h40;

    logic Clock = 1'b0;
    logic rstN;
    logic hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut;
    logic marIn, zIn, pcIn, mdrIn, irIn, yIn, hiIn, loIn, outportIn;
    logic inportStrobe, incPc, gra, grb, grc, rIn, rOut, baOut, conIn;
    logic memRead, memWrite, memOverride;
    aluOp_t opcode;
    logic [DataWidth-1:0] inportData, overrideData, busValue, outportData;
    logic [AddrWidth-1:0] overrideAddr, marAddress;
    logic conFf;

    logic [31:0] expBus, expOut, modelPc;
    logic [AddrWidth-1:0] expMar;
    logic [1:0] modelC2;   // c2 field currently in IR
    logic expCon;
    logic [31:0] lfsrState = 32'hbaeb8e01;
    int errorCount = 0;
    int cycleCount = 0;

    logic [AddrWidth-1:0] addr;
    logic [31:0] word;
    aluOp_t op;

    busCpuDatapath dut (.*);

    always #20 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run hung, no end after %0d cycles", cycleCount);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] result;
        logic feedback;
        result = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            result = {result[30:0], feedback};
        end
        return result;
    endfunction

    function automatic logic [31:0] regInstr(input logic [3:0] ra, input logic [3:0] rb,
                                             input logic [3:0] rc);
        return {5'b0, ra, rb, rc, 15'b0};
    endfunction

    function automatic logic branchTaken(input logic [1:0] c2, input logic [31:0] value);
        case (c2)
            2'b00:   return value == 0;
            2'b01:   return value != 0;
            2'b10:   return !value[31];
            default: return value[31];
        endcase
    endfunction

    // Upper half of Z is the sign of the low word except for multiply
    function automatic logic [63:0] aluModel(input aluOp_t sel, input logic [31:0] y,
                                             input logic [31:0] b);
        logic [31:0] low;
        logic signed [63:0] wideY;
        logic signed [63:0] wideB;
        wideY = {{32{y[31]}}, y};
        wideB = {{32{b[31]}}, b};
        case (sel)
            OpAdd:   low = y + b;
            OpSub:   low = y - b;
            OpAnd:   low = y & b;
            OpOr:    low = y | b;
            OpShr:   low = y >> b[4:0];
            OpShl:   low = y << b[4:0];
            OpNeg:   low = 32'd0 - b;
            OpNot:   low = ~b;
            default: return wideY * wideB;
        endcase
        return {{32{low[31]}}, low};
    endfunction

    `include "datapathTbTasks.svh"

    assert property (@(posedge Clock) disable iff (!rstN) busValue == expBus)
        else reportMismatch("busValue", $sampled(expBus), $sampled(busValue));
    assert property (@(posedge Clock) disable iff (!rstN) outportData == expOut)
        else reportMismatch("outportData", $sampled(expOut), $sampled(outportData));
    assert property (@(posedge Clock) disable iff (!rstN) conFf == expCon)
        else reportMismatch("conFf", 32'($sampled(expCon)), 32'($sampled(conFf)));
    assert property (@(posedge Clock) disable iff (!rstN) marAddress == expMar)
        else reportMismatch("marAddress", 32'($sampled(expMar)), 32'($sampled(marAddress)));

    initial begin
        rstN = 1'b0;
        clearStrobes();
        opcode = OpAdd;
        inportData = '0;
        overrideAddr = '0;
        overrideData = '0;
        {expBus, expOut, modelPc, expMar, modelC2, expCon} = '0;
        repeat (10) @(posedge Clock);
        #2;
        rstN = 1'b1;
        endCycle('0);   // Everything reads zero after reset
        endCycle('0);

        addr = randomBits(AddrWidth);   // ldi through MAR and MDR
        word = randomBits(32);
        preloadWord(addr, word);
        busTransfer(regInstr(4'd5, 4'd0, 4'd0), ToIr);
        busTransfer(32'(addr), ToPc);
        {pcOut, marIn} = '1;
        endCycle(32'(addr));
        expMar = addr;
        {memRead, mdrIn} = '1;
        endCycle('0);
        {mdrOut, rIn, gra} = '1;
        endCycle(word);
        {rOut, gra} = '1;
        endCycle(word);
        {baOut, gra} = '1;   // Nonzero register under baOut
        endCycle(word);
        loadReg(4'd0, word | 32'h1);
        {baOut, gra} = '1;
        endCycle('0);

        op = op.first();
        repeat (op.num()) begin
            repeat (3) aluOp(op, randomBits(32), randomBits(32));
            op = op.next();
        end

        fetch(randomBits(32) | 32'h0004_0000);   // Negative imm
        fetch(randomBits(32) & ~32'h0004_0000);

        for (int c = 0; c < 4; c++) begin
            busTransfer({9'b0, 2'(c), 21'b0}, ToIr);
            busTransfer('0, ToCon);
            busTransfer(randomBits(31) | 32'h1, ToCon);
            busTransfer(randomBits(31) | 32'h8000_0000, ToCon);
        end

        busTransfer(randomBits(32), ToOut);   // Inport straight to outport
        addr = randomBits(AddrWidth);
        word = randomBits(32);
        busTransfer(32'(addr), ToMar);
        busTransfer(word, ToMdr);
        memWrite = 1'b1;
        endCycle('0);
        busTransfer(~word, ToMdr);   // MDR differs from RAM before the read
        {memRead, mdrIn} = '1;
        endCycle('0);
        mdrOut = 1'b1;
        endCycle(word);

        @(posedge Clock);
        #1;
        $display("Checks done after %0d cycles, %0d error(s)", cycleCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- busCpuDatapath.f
+incdir+tests
verilog/cpuPkg.sv
verilog/busSourcesIf.sv
verilog/busMux.sv
verilog/registerFile.sv
verilog/instructionUnit.sv
verilog/aluUnit.sv
verilog/memoryInterface.sv
verilog/ioPorts.sv
verilog/busCpuDatapath.sv
tests/datapathTb.sv

//--- Bender.yml
package:
  name: busCpuDatapath

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/busSourcesIf.sv
      - verilog/busMux.sv
      - verilog/registerFile.sv
      - verilog/instructionUnit.sv
      - verilog/aluUnit.sv
      - verilog/memoryInterface.sv
      - verilog/ioPorts.sv
      - verilog/busCpuDatapath.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/datapathTb.sv
